// File: opl_phase_params.svh
// ~~~~~~~~~~~~~~~~~~~~
// Widths and counts for the phase generator. The slot index width must
// cover OPL_NUM_SLOTS, and OPL_PIPE_LATENCY must match the RTL pipeline.
// ~~~~~~~~~~~~~~~~~~~~
`ifndef OPL_PHASE_PARAMS_SVH
`define OPL_PHASE_PARAMS_SVH

`define OPL_NUM_SLOTS     36    // Two banks of 18 operators.
`define OPL_SLOT_WIDTH    6     // Enough bits for slot indices 0 to 35.
`define OPL_FNUM_WIDTH    10    // Frequency number register width.
`define OPL_BLOCK_WIDTH   3     // Octave select.
`define OPL_MULT_WIDTH    4     // Multiple code.
`define OPL_PHASE_WIDTH   20    // Phase accumulator width, wraps modulo 2^20.

// Samples spent at each of the 8 vibrato positions.
`define OPL_VIB_PERIOD    1024

// Cycles from a slot strobe to the matching phase output.
`define OPL_PIPE_LATENCY  4

`endif

// File: opl_phase_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared types of the phase generator. Widths come from the params
// header, so this package compiles first.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "opl_phase_params.svh"

package opl_phase_pkg;

    typedef logic [`OPL_SLOT_WIDTH-1:0]         slot_t;    // Operator slot index.
    typedef logic [`OPL_FNUM_WIDTH-1:0]         fnum_t;    // Frequency number.
    typedef logic [`OPL_BLOCK_WIDTH-1:0]        block_t;   // Octave.
    typedef logic [`OPL_MULT_WIDTH-1:0]         mult_t;    // Multiple code.
    typedef logic [`OPL_PHASE_WIDTH-1:0]        phase_t;   // Phase or phase increment.
    typedef logic signed [`OPL_FNUM_WIDTH-1:0]  vib_off_t; // Signed vibrato offset.

    // Per-slot configuration word; key-on travels separately.
    typedef struct packed {
        fnum_t  fnum;
        block_t block;
        mult_t  mult;
        logic   vib;    // Vibrato enable.
    } slot_cfg_t;

    // One entry of the output phase stream.
    typedef struct packed {
        slot_t  slot;
        phase_t phase;
    } slot_phase_t;

    // Sequencer states.
    typedef enum logic [1:0] {
        SEQ_CLEAR,  // Post-reset accumulator clear sweep.
        SEQ_IDLE,   // Waiting for the next sample pulse.
        SEQ_RUN     // Walking through all slots.
    } seq_state_t;

endpackage

`default_nettype wire

// File: slot_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~
// Control FSM for the slot walk. A sample pulse that arrives while the
// sweep or a walk is running is dropped and flagged, never queued.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "opl_phase_params.svh"

module slot_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sample_clk_en,
    output logic                 slot_strobe,
    output opl_phase_pkg::slot_t slot_idx,
    output logic                 acc_clear_all,
    output logic                 sample_done,
    output logic                 busy,
    output logic                 sample_overrun
);

    localparam opl_phase_pkg::slot_t LAST_SLOT = opl_phase_pkg::slot_t'(`OPL_NUM_SLOTS - 1);

    opl_phase_pkg::seq_state_t state;
    opl_phase_pkg::slot_t      slot_cnt;     // Slot being cleared or walked.
    logic                      last_slot;

    assign last_slot = (slot_cnt == LAST_SLOT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= opl_phase_pkg::SEQ_CLEAR;  // Sweep starts right after reset.
            slot_cnt    <= '0;
            sample_done <= 1'b0;
        end else begin
            // Registered so the last slot still reads the old vibrato position.
            sample_done <= (state == opl_phase_pkg::SEQ_RUN) && last_slot;
            case (state)
                opl_phase_pkg::SEQ_CLEAR: begin
                    slot_cnt <= last_slot ? '0 : slot_cnt + 1'b1;
                    if (last_slot) begin
                        state <= opl_phase_pkg::SEQ_IDLE;
                    end
                end
                opl_phase_pkg::SEQ_IDLE: begin
                    slot_cnt <= '0;
                    if (sample_clk_en) begin
                        state <= opl_phase_pkg::SEQ_RUN;  // Walk starts next cycle.
                    end
                end
                opl_phase_pkg::SEQ_RUN: begin
                    slot_cnt <= last_slot ? '0 : slot_cnt + 1'b1;
                    if (last_slot) begin
                        state <= opl_phase_pkg::SEQ_IDLE;
                    end
                end
                default: state <= opl_phase_pkg::SEQ_CLEAR;
            endcase
        end
    end

    assign slot_idx       = slot_cnt;                              // Shared by sweep and walk.
    assign slot_strobe    = (state == opl_phase_pkg::SEQ_RUN);     // One slot per clock.
    assign acc_clear_all  = (state == opl_phase_pkg::SEQ_CLEAR);
    assign busy           = (state != opl_phase_pkg::SEQ_IDLE);
    assign sample_overrun = sample_clk_en && busy;                 // Early pulse is dropped.

endmodule

`default_nettype wire

// File: slot_cfg_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// Slot configuration registers with one registered read port.
// A write lands from the slot's next read; key-on clears on that read.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module slot_cfg_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cfg_wr,
    input  opl_phase_pkg::slot_t     cfg_slot,
    input  opl_phase_pkg::slot_cfg_t cfg_data,
    input  logic                     cfg_key_on,
    input  logic                     slot_strobe,
    input  opl_phase_pkg::slot_t     slot_idx,
    output logic                     rd_strobe,
    output opl_phase_pkg::slot_t     rd_slot,
    output opl_phase_pkg::slot_cfg_t rd_cfg,
    output logic                     rd_clear
);

    localparam int NUM_SLOTS = `OPL_NUM_SLOTS;

    opl_phase_pkg::slot_cfg_t cfg_mem [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]     key_pending;    // One clear request per slot.
    logic                     wr_ok;          // Write address is a real slot.

    assign wr_ok = cfg_wr && (cfg_slot < opl_phase_pkg::slot_t'(NUM_SLOTS));

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                cfg_mem[i] <= '0;
            end
            key_pending <= '0;
            rd_strobe   <= 1'b0;
        end else begin
            rd_strobe <= slot_strobe;
            if (slot_strobe) begin
                key_pending[slot_idx] <= 1'b0;     // The read consumes the request.
            end
            if (wr_ok) begin
                cfg_mem[cfg_slot] <= cfg_data;
                if (cfg_key_on) begin
                    key_pending[cfg_slot] <= 1'b1; // Wins over a read in the same cycle.
                end
            end
        end
    end

    // Read data is payload and follows the strobe by one cycle.
    always_ff @(posedge clk) begin
        if (slot_strobe) begin
            rd_slot  <= slot_idx;
            rd_cfg   <= cfg_mem[slot_idx];
            rd_clear <= key_pending[slot_idx];
        end
    end

endmodule

`default_nettype wire

// File: vibrato.sv
// ~~~~~~~~~~~~~~~~~~~~
// Vibrato position counter, stepped once per VIB_PERIOD samples.
// The offset output is combinational in fnum and dvb.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module vibrato #(
    parameter int VIB_PERIOD = `OPL_VIB_PERIOD
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sample_done,
    input  logic                    dvb,
    input  opl_phase_pkg::fnum_t    fnum,
    output opl_phase_pkg::vib_off_t vib_off
);

    localparam int CNT_W = (VIB_PERIOD > 1) ? $clog2(VIB_PERIOD) : 1;

    logic [CNT_W-1:0]        sample_cnt;  // Samples spent at the current position.
    logic [2:0]              vib_pos;     // One of 8 positions in the vibrato cycle.
    opl_phase_pkg::vib_off_t delta;       // Peak offset for this fnum.
    opl_phase_pkg::vib_off_t half;

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_cnt <= '0;
            vib_pos    <= '0;
        end else if (sample_done) begin
            if (sample_cnt == CNT_W'(VIB_PERIOD - 1)) begin
                sample_cnt <= '0;
                vib_pos    <= vib_pos + 3'd1;   // Wraps after position 7.
            end else begin
                sample_cnt <= sample_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        // Deep vibrato uses the top 3 bits of fnum, normal the top 2.
        delta = opl_phase_pkg::vib_off_t'(dvb ? (fnum >> 7) : (fnum >> 8));
        half  = delta >>> 1;                   // Positive, so this truncates.
        case (vib_pos)
            3'd0:    vib_off = '0;
            3'd1:    vib_off = half;
            3'd2:    vib_off = delta;
            3'd3:    vib_off = half;
            3'd4:    vib_off = '0;
            3'd5:    vib_off = -half;
            3'd6:    vib_off = -delta;
            default: vib_off = -half;
        endcase
    end

endmodule

`default_nettype wire

// File: calc_phase_inc.sv
// ~~~~~~~~~~~~~~~~~~~~
// Two-stage phase increment pipeline. Results wrap modulo 2^20, so
// large fnum, block and multiple settings alias.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module calc_phase_inc #(
    parameter int VIB_PERIOD = `OPL_VIB_PERIOD
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rd_strobe,
    input  opl_phase_pkg::slot_t     rd_slot,
    input  opl_phase_pkg::slot_cfg_t rd_cfg,
    input  logic                     rd_clear,
    input  logic                     dvb,
    input  logic                     sample_done,
    output logic                     inc_strobe,
    output opl_phase_pkg::slot_t     inc_slot,
    output logic                     inc_clear,
    output opl_phase_pkg::phase_t    phase_inc
);

    localparam int PW = $bits(opl_phase_pkg::phase_t);
    localparam int VW = $bits(opl_phase_pkg::vib_off_t);

    opl_phase_pkg::phase_t    pre_mult;      // fnum shifted by block.
    logic [3:0]               factor;        // Multiplier for codes 1 to 15.
    opl_phase_pkg::phase_t    mult_prod;
    opl_phase_pkg::vib_off_t  vib_off;
    logic signed [PW-1:0]     vib_ext;       // Sign-extended offset.
    opl_phase_pkg::phase_t    vib_shift;     // Offset scaled by the octave.

    logic                     strobe_p1;
    opl_phase_pkg::slot_t     slot_p1;
    logic                     clear_p1;
    logic                     vib_p1;        // Vibrato enable delayed with the data.
    opl_phase_pkg::phase_t    prod_p1;
    opl_phase_pkg::phase_t    vib_shift_p1;

    assign pre_mult = opl_phase_pkg::phase_t'(rd_cfg.fnum) << rd_cfg.block;

    always_comb begin
        case (rd_cfg.mult)
            4'h0, 4'h1: factor = 4'd1;   // Code 0 halves below.
            4'h2:       factor = 4'd2;
            4'h3:       factor = 4'd3;
            4'h4:       factor = 4'd4;
            4'h5:       factor = 4'd5;
            4'h6:       factor = 4'd6;
            4'h7:       factor = 4'd7;
            4'h8:       factor = 4'd8;
            4'h9:       factor = 4'd9;
            4'hA, 4'hB: factor = 4'd10;
            4'hC, 4'hD: factor = 4'd12;
            default:    factor = 4'd15;
        endcase
        mult_prod = (rd_cfg.mult == 4'h0) ? (pre_mult >> 1)
                                          : pre_mult * opl_phase_pkg::phase_t'(factor);
        vib_ext   = {{(PW - VW){vib_off[VW-1]}}, vib_off};
        vib_shift = opl_phase_pkg::phase_t'(vib_ext <<< rd_cfg.block);
    end

    vibrato #(
        .VIB_PERIOD (VIB_PERIOD)
    ) i_vibrato (
        .clk         (clk),
        .rst         (rst),
        .sample_done (sample_done),
        .dvb         (dvb),
        .fnum        (rd_cfg.fnum),
        .vib_off     (vib_off)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            strobe_p1  <= 1'b0;
            inc_strobe <= 1'b0;
        end else begin
            strobe_p1  <= rd_strobe;
            inc_strobe <= strobe_p1;
        end
    end

    // Payload stages advance every cycle; several slots are in flight.
    always_ff @(posedge clk) begin
        slot_p1      <= rd_slot;
        clear_p1     <= rd_clear;
        vib_p1       <= rd_cfg.vib;
        prod_p1      <= mult_prod;
        vib_shift_p1 <= vib_shift;
        inc_slot     <= slot_p1;
        inc_clear    <= clear_p1;
        phase_inc    <= prod_p1 + (vib_p1 ? vib_shift_p1 : '0);  // Two's complement wrap.
    end

endmodule

`default_nettype wire

// File: phase_accumulator.sv
// ~~~~~~~~~~~~~~~~~~~~
// Per-slot phase memory with read-modify-write. Relies on the clear
// sweep after reset, since the memory itself has no reset.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "opl_phase_params.svh"

module phase_accumulator (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       acc_clear_all,
    input  opl_phase_pkg::slot_t       slot_idx,
    input  logic                       inc_strobe,
    input  opl_phase_pkg::slot_t       inc_slot,
    input  logic                       inc_clear,
    input  opl_phase_pkg::phase_t      phase_inc,
    output logic                       phase_valid,
    output opl_phase_pkg::slot_phase_t phase_out
);

    opl_phase_pkg::phase_t acc_mem [`OPL_NUM_SLOTS];
    opl_phase_pkg::phase_t acc_next;    // Value written back and sent out.

    // Key-on loads the bare increment, so the first phase equals it.
    always_comb begin
        if (inc_clear) begin
            acc_next = phase_inc;
        end else begin
            acc_next = acc_mem[inc_slot] + phase_inc;   // Wraps modulo 2^20.
        end
    end

    always_ff @(posedge clk) begin
        if (acc_clear_all) begin
            acc_mem[slot_idx] <= '0;            // Sweep never overlaps a strobe.
        end else if (inc_strobe) begin
            acc_mem[inc_slot] <= acc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_valid <= 1'b0;
        end else begin
            phase_valid <= inc_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (inc_strobe) begin
            phase_out.slot  <= inc_slot;
            phase_out.phase <= acc_next;
        end
    end

endmodule

`default_nettype wire

// File: opl_phase_gen.sv
// ~~~~~~~~~~~~~~~~~~~~
// Phase generator top. First phase_valid comes 5 cycles after an
// accepted sample pulse; the output stream cannot be stalled.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "opl_phase_params.svh"

module opl_phase_gen #(
    parameter int VIB_PERIOD = `OPL_VIB_PERIOD
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sample_clk_en,
    input  logic                       dvb,
    input  logic                       cfg_wr,
    input  opl_phase_pkg::slot_t       cfg_slot,
    input  opl_phase_pkg::slot_cfg_t   cfg_data,
    input  logic                       cfg_key_on,
    output logic                       phase_valid,
    output opl_phase_pkg::slot_phase_t phase_out,
    output logic                       busy,
    output logic                       sample_overrun
);

    logic                     slot_strobe, acc_clear_all, sample_done;
    opl_phase_pkg::slot_t     slot_idx;
    logic                     rd_strobe, rd_clear;      // Stage 0 outputs.
    opl_phase_pkg::slot_t     rd_slot;
    opl_phase_pkg::slot_cfg_t rd_cfg;
    logic                     inc_strobe, inc_clear;    // Stage 2 outputs.
    opl_phase_pkg::slot_t     inc_slot;
    opl_phase_pkg::phase_t    phase_inc;

    slot_sequencer i_slot_sequencer (
        .clk, .rst, .sample_clk_en, .slot_strobe, .slot_idx,
        .acc_clear_all, .sample_done, .busy, .sample_overrun
    );

    slot_cfg_regs i_slot_cfg_regs (
        .clk, .rst, .cfg_wr, .cfg_slot, .cfg_data, .cfg_key_on,
        .slot_strobe, .slot_idx, .rd_strobe, .rd_slot, .rd_cfg, .rd_clear
    );

    calc_phase_inc #(
        .VIB_PERIOD (VIB_PERIOD)
    ) i_calc_phase_inc (
        .clk, .rst, .rd_strobe, .rd_slot, .rd_cfg, .rd_clear, .dvb,
        .sample_done, .inc_strobe, .inc_slot, .inc_clear, .phase_inc
    );

    phase_accumulator i_phase_accumulator (
        .clk, .rst, .acc_clear_all, .slot_idx, .inc_strobe, .inc_slot,
        .inc_clear, .phase_inc, .phase_valid, .phase_out
    );

endmodule

`default_nettype wire

// File: opl_phase_gen_assert.sv
// ~~~~~~~~~~~~~~~~~~~~
// Output timing checks, bound into the phase generator top.
// Slot order is checked only across back-to-back valid cycles.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "opl_phase_params.svh"

module opl_phase_gen_assert (
    input logic                       clk,
    input logic                       rst,
    input logic                       phase_valid,
    input opl_phase_pkg::slot_phase_t phase_out,
    input logic                       busy,
    input logic                       sample_overrun
);

    localparam int NUM_SLOTS = `OPL_NUM_SLOTS;

    int fail_reset   = 0;  // Failure counts, summed by the testbench.
    int fail_order   = 0;
    int fail_overrun = 0;

    logic in_sweep;        // High from reset until the clear sweep has ended.
    logic overrun_seen;    // A sample pulse was dropped in this busy period.
    int   busy_cycles;     // Cycles that busy has been high in a row.

    always_ff @(posedge clk) begin
        if (rst) begin
            in_sweep     <= 1'b1;
            overrun_seen <= 1'b0;
            busy_cycles  <= 0;
        end else begin
            if (!busy) begin
                in_sweep <= 1'b0;                  // Sweep is over once busy drops.
            end
            overrun_seen <= busy && (overrun_seen || sample_overrun);
            busy_cycles  <= busy ? busy_cycles + 1 : 0;
        end
    end

    // No slot output during reset or the accumulator clear sweep.
    valid_in_reset: assert property (@(posedge clk) in_sweep |-> !phase_valid)
        else begin
            fail_reset++;
            $error("phase_valid high during reset or the clear sweep");
        end

    slot_order: assert property (@(posedge clk) disable iff (rst)
        (phase_valid && $past(phase_valid)) |->
            (phase_out.slot == opl_phase_pkg::slot_t'($past(phase_out.slot) + 1'b1)))
        else begin
            fail_order++;
            $error("slot index did not step by one between valid cycles");
        end

    // A dropped pulse must not stretch the sweep or walk it arrived in.
    overrun_when_busy: assert property (@(posedge clk) disable iff (rst)
        (overrun_seen && busy) |-> (busy_cycles < NUM_SLOTS))
        else begin
            fail_overrun++;
            $error("busy stayed high past one slot walk after a dropped sample pulse");
        end

endmodule

bind opl_phase_gen opl_phase_gen_assert i_opl_phase_gen_assert (
    .clk            (clk),
    .rst            (rst),
    .phase_valid    (phase_valid),
    .phase_out      (phase_out),
    .busy           (busy),
    .sample_overrun (sample_overrun)
);

`default_nettype wire

// File: tb_opl_phase_gen.sv
// ~~~~~~~~~~~~~~~~~~~~
// Directed tests of the phase generator against a behavioral model.
// Config writes are only issued while the DUT is idle between samples.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "opl_phase_params.svh"

module tb_opl_phase_gen;

    localparam int NUM_SLOTS       = `OPL_NUM_SLOTS;
    localparam int VIB_PERIOD      = 4;                        // Fast vibrato steps.
    localparam int LATENCY         = 1 + `OPL_PIPE_LATENCY;    // Pulse to first valid.
    localparam int RESET_CYCLES    = 4;
    localparam int IDLE_TIMEOUT    = 100;                      // Longer than a clear sweep.
    localparam int NUM_TESTS       = 5;
    localparam int MAX_SAMPLES     = 64;                       // Longest test, in samples.
    localparam int WATCHDOG_CYCLES = NUM_TESTS * MAX_SAMPLES * 60 + 200;

    logic                       clk;
    logic                       rst;
    logic                       sample_clk_en;
    logic                       dvb;
    logic                       cfg_wr;
    opl_phase_pkg::slot_t       cfg_slot;
    opl_phase_pkg::slot_cfg_t   cfg_data;
    logic                       cfg_key_on;
    logic                       phase_valid;
    opl_phase_pkg::slot_phase_t phase_out;
    logic                       busy;
    logic                       sample_overrun;

    opl_phase_pkg::slot_cfg_t model_cfg [NUM_SLOTS];  // Config as last written.
    opl_phase_pkg::phase_t    model_acc [NUM_SLOTS];  // Expected accumulators.
    logic                     model_key [NUM_SLOTS];  // Key-on seen, slot not yet read.
    int                       samples_done;           // Accepted samples, sets vibrato position.
    logic [15:0]              lfsr;
    int                       checks;
    int                       errors;

    opl_phase_gen #(
        .VIB_PERIOD (VIB_PERIOD)
    ) i_opl_phase_gen (
        .clk, .rst, .sample_clk_en, .dvb, .cfg_wr, .cfg_slot, .cfg_data,
        .cfg_key_on, .phase_valid, .phase_out, .busy, .sample_overrun
    );

    always #5 clk = ~clk;

    // Galois LFSR with taps 16, 14, 13 and 11, one step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return value;
    endfunction

    // Twice the multiple factor, so code 0 gives one half.
    function automatic int mult_x2(input opl_phase_pkg::mult_t code);
        case (code)
            4'h0:       return 1;
            4'hA, 4'hB: return 20;
            4'hC, 4'hD: return 24;
            4'hE, 4'hF: return 30;
            default:    return 2 * int'(code);
        endcase
    endfunction

    function automatic int vib_offset(input opl_phase_pkg::fnum_t fnum, input logic deep,
                                      input int pos);
        int delta;
        int half;
        delta = deep ? (int'(fnum) >> 7) : (int'(fnum) >> 8);
        half  = delta / 2;                               // Truncates, delta is never negative.
        case (pos)
            1, 3:    return half;
            2:       return delta;
            5, 7:    return -half;
            6:       return -delta;
            default: return 0;
        endcase
    endfunction

    function automatic opl_phase_pkg::phase_t expected_inc(input opl_phase_pkg::slot_cfg_t cfg,
                                                           input logic deep, input int pos);
        int total;
        total = (int'(cfg.fnum) << cfg.block) * mult_x2(cfg.mult) / 2;
        if (cfg.vib) begin
            total = total + vib_offset(cfg.fnum, deep, pos) * (1 << cfg.block);
        end
        return opl_phase_pkg::phase_t'(total);           // Low 20 bits, wraps like the DUT.
    endfunction

    task automatic check_phase(input string name, input opl_phase_pkg::slot_phase_t exp,
                               input opl_phase_pkg::slot_phase_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected slot %0d phase 0x%05h, actual slot %0d phase 0x%05h",
                     name, exp.slot, exp.phase, act.slot, act.phase);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic wait_idle(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy !== 1'b0 && cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy !== 1'b0) begin
            errors++;
            $display("Error %s: busy stayed high for %0d cycles", name, IDLE_TIMEOUT);
        end
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_flag({name, " no output"}, 1'b0, phase_valid);
        end
    endtask

    task automatic write_cfg(input opl_phase_pkg::slot_t slot,
                             input opl_phase_pkg::slot_cfg_t cfg, input logic key_on);
        @(posedge clk);
        cfg_wr     <= 1'b1;
        cfg_slot   <= slot;
        cfg_data   <= cfg;
        cfg_key_on <= key_on;
        @(posedge clk);
        cfg_wr     <= 1'b0;
        cfg_key_on <= 1'b0;
        model_cfg[slot] = cfg;
        if (key_on) begin
            model_key[slot] = 1'b1;                      // Applies on the slot's next read.
        end
    endtask

    task automatic load_random_cfgs(input logic with_vib);
        opl_phase_pkg::slot_cfg_t cfg;
        opl_phase_pkg::mult_t     mask;
        mask = opl_phase_pkg::mult_t'(rand_bits(4));
        for (int s = 0; s < NUM_SLOTS; s++) begin
            cfg.fnum  = opl_phase_pkg::fnum_t'(rand_bits(10));
            cfg.block = opl_phase_pkg::block_t'(rand_bits(3));
            cfg.mult  = opl_phase_pkg::mult_t'(s) ^ mask;  // All 16 codes over 36 slots.
            cfg.vib   = 1'b0;
            if (with_vib) begin
                cfg.vib = (rand_bits(1) != 0);
            end
            write_cfg(opl_phase_pkg::slot_t'(s), cfg, 1'b0);
        end
    endtask

    // One slot walk; overrun_at >= 0 injects an early pulse after that output.
    task automatic run_sample(input string name, input int overrun_at);
        opl_phase_pkg::slot_phase_t exp;
        opl_phase_pkg::phase_t      inc;
        int                         pos;
        wait_idle(name);
        pos = (samples_done / VIB_PERIOD) % 8;
        @(posedge clk);
        sample_clk_en <= 1'b1;
        @(posedge clk);
        sample_clk_en <= 1'b0;
        for (int k = 1; k < LATENCY; k++) begin
            @(negedge clk);
            check_flag({name, " latency"}, 1'b0, phase_valid);
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            inc          = expected_inc(model_cfg[s], dvb, pos);
            model_acc[s] = model_key[s] ? inc : model_acc[s] + inc;
            model_key[s] = 1'b0;
            exp.slot     = opl_phase_pkg::slot_t'(s);
            exp.phase    = model_acc[s];
            @(negedge clk);
            check_flag({name, " valid"}, 1'b1, phase_valid);
            check_phase(name, exp, phase_out);
            check_flag({name, " overrun"}, (overrun_at >= 0) && (s == overrun_at + 1),
                       sample_overrun);
            if (s == overrun_at) begin
                @(posedge clk);
                sample_clk_en <= 1'b1;                   // Lands while the walk is busy.
            end else if (overrun_at >= 0 && s == overrun_at + 1) begin
                @(posedge clk);
                sample_clk_en <= 1'b0;
            end
        end
        @(negedge clk);
        check_flag({name, " end"}, 1'b0, phase_valid);
        samples_done++;
    endtask

    task automatic reset_and_first_sample();
        @(negedge clk);
        check_flag("reset busy", 1'b1, busy);
        check_flag("reset valid", 1'b0, phase_valid);
        check_flag("reset overrun", 1'b0, sample_overrun);
        wait_idle("clear sweep");
        expect_quiet("idle", 20);
        load_random_cfgs(1'b0);
        run_sample("first sample", -1);                  // Accumulators start at zero.
    endtask

    task automatic accumulate_random();
        repeat (4) begin
            load_random_cfgs(1'b0);
            run_sample("accumulate", -1);
            run_sample("accumulate", -1);
        end
    endtask

    task automatic vibrato_sweep();
        load_random_cfgs(1'b1);
        for (int deep = 0; deep < 2; deep++) begin
            @(posedge clk);
            dvb <= (deep != 0);
            repeat (8 * VIB_PERIOD) begin                // All 8 positions per depth.
                run_sample(deep != 0 ? "vibrato deep" : "vibrato", -1);
            end
        end
    endtask

    task automatic key_on_restart();
        opl_phase_pkg::slot_cfg_t cfg;
        run_sample("key-on before", -1);
        cfg      = model_cfg[7];
        cfg.fnum = opl_phase_pkg::fnum_t'(rand_bits(10));
        write_cfg(6'd7, cfg, 1'b1);
        write_cfg(6'd8, model_cfg[8], 1'b0);             // Plain rewrite keeps accumulating.
        run_sample("key-on", -1);
        run_sample("key-on after", -1);
    endtask

    task automatic overrun_drop();
        run_sample("overrun", 10);
        expect_quiet("after overrun", 60);
        run_sample("after overrun", -1);
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        sample_clk_en = 1'b0;
        dvb           = 1'b0;
        cfg_wr        = 1'b0;
        cfg_slot      = '0;
        cfg_data      = '0;
        cfg_key_on    = 1'b0;
        lfsr          = 16'd46312;
        checks        = 0;
        errors        = 0;
        samples_done  = 0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            model_cfg[s] = '0;
            model_acc[s] = '0;
            model_key[s] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        reset_and_first_sample();
        accumulate_random();
        vibrato_sweep();
        key_on_restart();
        overrun_drop();
        errors += i_opl_phase_gen.i_opl_phase_gen_assert.fail_reset
                + i_opl_phase_gen.i_opl_phase_gen_assert.fail_order
                + i_opl_phase_gen.i_opl_phase_gen_assert.fail_overrun;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: opl_phase_gen.f
+incdir+.
opl_phase_pkg.sv
slot_sequencer.sv
slot_cfg_regs.sv
vibrato.sv
calc_phase_inc.sv
phase_accumulator.sv
opl_phase_gen.sv
opl_phase_gen_assert.sv
tb_opl_phase_gen.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the phase generator testbench with Verilator and runs it.
# Exits non-zero unless the simulation prints the pass message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f opl_phase_gen.f --top-module tb_opl_phase_gen -o tb_sim \
    && ./obj_dir/tb_sim +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -Fx "Done: no errors" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
